// ==== source/vaiPkg.sv ====
`default_nettype none

package vaiPkg;

    // Every bus in the multiplexer uses the same address and data widths.
    parameter int ADDR_WIDTH = 32;
    parameter int DATA_WIDTH = 32;

    // Register select inside one sub-accelerator's block of the configuration space.
    // It is decoded from configuration address bits [3:2].
    typedef enum logic [1:0]
    {
        cfgOffset = 2'd0,
        cfgLimit  = 2'd1,
        cfgEnable = 2'd2
    } cfgReg_e;

    // Configuration address bit where the sub-accelerator index starts.
    parameter int CFG_IDX_LSB = 4;

    // States of the per-port audit stage.
    // A rejected request stays in auditReject for exactly one cycle.
    typedef enum logic [1:0]
    {
        auditIdle    = 2'd0,
        auditForward = 2'd1,
        auditReject  = 2'd2
    } auditState_e;

endpackage

`default_nettype wire

// ==== source/vaiBusIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// Wishbone classic link between two blocks inside the multiplexer.
interface vaiBusIf;

    import vaiPkg::*;

    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [ADDR_WIDTH-1:0] adr;
    logic [DATA_WIDTH-1:0] datW;
    logic [DATA_WIDTH-1:0] datR;
    logic                  ack;
    logic                  err;

    // The master opens the cycle and owns the request fields.
    modport master
    (
        output cyc, stb, we, adr, datW,
        input  datR, ack, err
    );

    // The slave terminates the cycle with ack or err.
    modport slave
    (
        input  cyc, stb, we, adr, datW,
        output datR, ack, err
    );

endinterface

`default_nettype wire

// ==== source/vaiOffsetTable.sv ====
`timescale 1ns/1ps
`default_nettype none

module vaiOffsetTable #(
    parameter int NUM_SUB_AFUS = 4
)
(
    input  logic                          pClk,
    input  logic                          reset,
    input  logic                          cfgCyc,
    input  logic                          cfgStb,
    input  logic                          cfgWe,
    input  logic [vaiPkg::ADDR_WIDTH-1:0] cfgAdr,
    input  logic [vaiPkg::DATA_WIDTH-1:0] cfgDatW,
    output logic [vaiPkg::DATA_WIDTH-1:0] cfgDatR,
    output logic                          cfgAck,
    output logic [vaiPkg::ADDR_WIDTH-1:0] offsets [NUM_SUB_AFUS],
    output logic [vaiPkg::ADDR_WIDTH-1:0] limits  [NUM_SUB_AFUS],
    output logic                          enables [NUM_SUB_AFUS]
);

    import vaiPkg::*;

    localparam int IDX_W = (NUM_SUB_AFUS > 1) ? $clog2(NUM_SUB_AFUS) : 1;

    cfgReg_e          regSel;
    logic [IDX_W-1:0] idx;
    logic             idxValid;
    logic             access;

    // Address layout is {index, register, 2'b00}, one word per register.
    assign regSel   = cfgReg_e'(cfgAdr[3:2]);
    assign idx      = cfgAdr[CFG_IDX_LSB +: IDX_W];
    assign idxValid = (int'(idx) < NUM_SUB_AFUS);

    // A new access is seen once; the ack cycle itself is not a second access.
    assign access = cfgCyc & cfgStb & ~cfgAck;

    always_ff @(posedge pClk)
    begin
        if (reset)
        begin
            cfgAck <= 1'b0;
            for (int i = 0; i < NUM_SUB_AFUS; i++)
            begin
                offsets[i] <= '0;
                limits[i]  <= '0;
                enables[i] <= 1'b0;
            end
        end
        else
        begin
            cfgAck <= access;
            if (access && cfgWe && idxValid)
            begin
                case (regSel)
                    cfgOffset: offsets[idx] <= ADDR_WIDTH'(cfgDatW);
                    cfgLimit:  limits[idx]  <= ADDR_WIDTH'(cfgDatW);
                    cfgEnable: enables[idx] <= cfgDatW[0];
                    default:   ;
                endcase
            end
        end
    end

    // Read data is captured on the same edge that raises the ack.
    always_ff @(posedge pClk)
    begin
        if (access)
        begin
            cfgDatR <= '0;
            if (idxValid)
            begin
                case (regSel)
                    cfgOffset: cfgDatR <= DATA_WIDTH'(offsets[idx]);
                    cfgLimit:  cfgDatR <= DATA_WIDTH'(limits[idx]);
                    cfgEnable: cfgDatR <= DATA_WIDTH'(enables[idx]);
                    default:   cfgDatR <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/vaiAuditTx.sv ====
`timescale 1ns/1ps
`default_nettype none

module vaiAuditTx
(
    input  logic                          pClk,
    input  logic                          reset,
    vaiBusIf.slave                        afu,
    vaiBusIf.master                       up,
    input  logic [vaiPkg::ADDR_WIDTH-1:0] offset,
    input  logic [vaiPkg::ADDR_WIDTH-1:0] limit,
    input  logic                          enable
);

    import vaiPkg::*;

    auditState_e           state;
    auditState_e           stateNext;
    logic [ADDR_WIDTH-1:0] adrReg;
    logic [DATA_WIDTH-1:0] datWReg;
    logic                  weReg;
    logic                  newReq;
    logic                  inWindow;
    logic                  upDone;

    assign newReq = afu.cyc & afu.stb;

    // The window is zero based, so the check is a single compare against the limit.
    assign inWindow = enable & (afu.adr < limit);

    assign upDone = up.ack | up.err;

    always_comb
    begin
        stateNext = state;
        case (state)
            auditIdle:
            begin
                if (newReq)
                begin
                    stateNext = inWindow ? auditForward : auditReject;
                end
            end
            auditForward:
            begin
                if (upDone)
                begin
                    stateNext = auditIdle;
                end
            end
            default: stateNext = auditIdle;
        endcase
    end

    always_ff @(posedge pClk)
    begin
        if (reset)
        begin
            state <= auditIdle;
        end
        else
        begin
            state <= stateNext;
        end
    end

    // The request is captured already translated into the upstream address space.
    always_ff @(posedge pClk)
    begin
        if (state == auditIdle && newReq)
        begin
            adrReg  <= afu.adr + offset;
            weReg   <= afu.we;
            datWReg <= afu.datW;
        end
    end

    assign up.cyc  = (state == auditForward);
    assign up.stb  = (state == auditForward);
    assign up.we   = weReg;
    assign up.adr  = adrReg;
    assign up.datW = datWReg;

    // Responses flow straight back; a rejected request is terminated locally.
    assign afu.ack  = (state == auditForward) & up.ack;
    assign afu.err  = (state == auditReject) | ((state == auditForward) & up.err);
    assign afu.datR = up.datR;

endmodule

`default_nettype wire

// ==== source/vaiArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module vaiArbiter #(
    parameter int NUM_SUB_AFUS = 4
)
(
    input  logic    pClk,
    input  logic    reset,
    vaiBusIf.slave  req [NUM_SUB_AFUS],
    vaiBusIf.master mem
);

    import vaiPkg::*;

    localparam int IDX_W = (NUM_SUB_AFUS > 1) ? $clog2(NUM_SUB_AFUS) : 1;

    logic [NUM_SUB_AFUS-1:0] reqActive;
    logic [NUM_SUB_AFUS-1:0] reqWe;
    logic [ADDR_WIDTH-1:0]   reqAdr  [NUM_SUB_AFUS];
    logic [DATA_WIDTH-1:0]   reqDatW [NUM_SUB_AFUS];

    logic             busy;
    logic [IDX_W-1:0] grantIdx;
    logic [IDX_W-1:0] lastIdx;
    logic [IDX_W-1:0] pickIdx;
    logic             pickValid;
    logic             memDone;

    assign memDone = mem.ack | mem.err;

    // Interface arrays need constant indices, so each port is flattened here.
    for (genvar i = 0; i < NUM_SUB_AFUS; i++)
    begin : genReq
        assign reqActive[i] = req[i].cyc & req[i].stb;
        assign reqWe[i]     = req[i].we;
        assign reqAdr[i]    = req[i].adr;
        assign reqDatW[i]   = req[i].datW;

        // Only the granted master sees the termination of the upstream cycle.
        assign req[i].ack  = busy & (grantIdx == IDX_W'(i)) & mem.ack;
        assign req[i].err  = busy & (grantIdx == IDX_W'(i)) & mem.err;
        assign req[i].datR = mem.datR;
    end

    // Search starts one past the last winner, which bounds the wait of every port.
    always_comb
    begin
        int cand;
        pickValid = 1'b0;
        pickIdx   = lastIdx;
        for (int k = 1; k <= NUM_SUB_AFUS; k++)
        begin
            cand = (int'(lastIdx) + k) % NUM_SUB_AFUS;
            if (!pickValid && reqActive[cand])
            begin
                pickValid = 1'b1;
                pickIdx   = IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge pClk)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            grantIdx <= '0;
            // Port 0 wins the first arbitration after reset.
            lastIdx  <= IDX_W'(NUM_SUB_AFUS - 1);
        end
        else if (busy)
        begin
            if (memDone)
            begin
                busy    <= 1'b0;
                lastIdx <= grantIdx;
            end
        end
        else if (pickValid)
        begin
            busy     <= 1'b1;
            grantIdx <= pickIdx;
        end
    end

    assign mem.cyc  = busy;
    assign mem.stb  = busy;
    assign mem.we   = reqWe[grantIdx];
    assign mem.adr  = reqAdr[grantIdx];
    assign mem.datW = reqDatW[grantIdx];

endmodule

`default_nettype wire

// ==== source/vaiMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module vaiMux #(
    parameter int NUM_SUB_AFUS = 4
)
(
    input  logic                                            pClk,
    input  logic                                            reset,

    // Sub-accelerator ports, one slice per requester.
    input  logic [NUM_SUB_AFUS-1:0]                         afuCyc,
    input  logic [NUM_SUB_AFUS-1:0]                         afuStb,
    input  logic [NUM_SUB_AFUS-1:0]                         afuWe,
    input  logic [NUM_SUB_AFUS-1:0][vaiPkg::ADDR_WIDTH-1:0] afuAdr,
    input  logic [NUM_SUB_AFUS-1:0][vaiPkg::DATA_WIDTH-1:0] afuDatW,
    output logic [NUM_SUB_AFUS-1:0][vaiPkg::DATA_WIDTH-1:0] afuDatR,
    output logic [NUM_SUB_AFUS-1:0]                         afuAck,
    output logic [NUM_SUB_AFUS-1:0]                         afuErr,

    // Shared upstream memory bus.
    output logic                                            memCyc,
    output logic                                            memStb,
    output logic                                            memWe,
    output logic [vaiPkg::ADDR_WIDTH-1:0]                   memAdr,
    output logic [vaiPkg::DATA_WIDTH-1:0]                   memDatW,
    input  logic [vaiPkg::DATA_WIDTH-1:0]                   memDatR,
    input  logic                                            memAck,

    // Host configuration port.
    input  logic                                            cfgCyc,
    input  logic                                            cfgStb,
    input  logic                                            cfgWe,
    input  logic [vaiPkg::ADDR_WIDTH-1:0]                   cfgAdr,
    input  logic [vaiPkg::DATA_WIDTH-1:0]                   cfgDatW,
    output logic [vaiPkg::DATA_WIDTH-1:0]                   cfgDatR,
    output logic                                            cfgAck
);

    import vaiPkg::*;

    logic [ADDR_WIDTH-1:0] offsets [NUM_SUB_AFUS];
    logic [ADDR_WIDTH-1:0] limits  [NUM_SUB_AFUS];
    logic                  enables [NUM_SUB_AFUS];

    vaiBusIf afuBus   [NUM_SUB_AFUS] ();
    vaiBusIf auditBus [NUM_SUB_AFUS] ();
    vaiBusIf memBus ();

    vaiOffsetTable #(
        .NUM_SUB_AFUS(NUM_SUB_AFUS)
    )
    uOffsetTable (
        .pClk(pClk),
        .reset(reset),
        .cfgCyc(cfgCyc),
        .cfgStb(cfgStb),
        .cfgWe(cfgWe),
        .cfgAdr(cfgAdr),
        .cfgDatW(cfgDatW),
        .cfgDatR(cfgDatR),
        .cfgAck(cfgAck),
        .offsets(offsets),
        .limits(limits),
        .enables(enables)
    );

    for (genvar i = 0; i < NUM_SUB_AFUS; i++)
    begin : genAfu
        assign afuBus[i].cyc  = afuCyc[i];
        assign afuBus[i].stb  = afuStb[i];
        assign afuBus[i].we   = afuWe[i];
        assign afuBus[i].adr  = afuAdr[i];
        assign afuBus[i].datW = afuDatW[i];
        assign afuDatR[i]     = afuBus[i].datR;
        assign afuAck[i]      = afuBus[i].ack;
        assign afuErr[i]      = afuBus[i].err;

        vaiAuditTx uAuditTx (
            .pClk(pClk),
            .reset(reset),
            .afu(afuBus[i]),
            .up(auditBus[i]),
            .offset(offsets[i]),
            .limit(limits[i]),
            .enable(enables[i])
        );
    end

    vaiArbiter #(
        .NUM_SUB_AFUS(NUM_SUB_AFUS)
    )
    uArbiter (
        .pClk(pClk),
        .reset(reset),
        .req(auditBus),
        .mem(memBus)
    );

    assign memCyc      = memBus.cyc;
    assign memStb      = memBus.stb;
    assign memWe       = memBus.we;
    assign memAdr      = memBus.adr;
    assign memDatW     = memBus.datW;
    assign memBus.datR = memDatR;
    assign memBus.ack  = memAck;
    // The upstream memory never signals an error.
    assign memBus.err  = 1'b0;

endmodule

`default_nettype wire

// ==== verification/vaiMux_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the upstream bus and on the arbiter grant inside vaiMux.
module vaiMux_checker #(
    parameter int NUM_SUB_AFUS = 4
)
(
    input logic                                                 pClk,
    input logic                                                 reset,
    input logic                                                 memCyc,
    input logic                                                 memStb,
    input logic [NUM_SUB_AFUS-1:0]                              afuAck,
    input logic [NUM_SUB_AFUS-1:0]                              afuErr,
    input logic [NUM_SUB_AFUS-1:0]                              fwdActive,
    input logic [$clog2(NUM_SUB_AFUS > 1 ? NUM_SUB_AFUS : 2)-1:0] grantIdx
);

    // A strobe is only legal inside an open cycle.
    assert property (@(posedge pClk) disable iff (reset) memStb |-> memCyc)
    else $error("memStb is high while memCyc is low");

    // While the upstream cycle is open, the granted audit stage must be forwarding.
    assert property (@(posedge pClk) disable iff (reset) memCyc |-> fwdActive[grantIdx])
    else $error("upstream cycle is open for an audit stage that is not forwarding");

    assert property (@(posedge pClk) disable iff (reset) (afuAck & afuErr) == '0)
    else $error("afuAck and afuErr are high together on one port");

    assert property (@(posedge pClk) reset |=> !memCyc)
    else $error("memCyc is high in the cycle after reset");

endmodule

bind vaiMux vaiMux_checker #(
    .NUM_SUB_AFUS(NUM_SUB_AFUS)
)
uChecker (
    .pClk(pClk),
    .reset(reset),
    .memCyc(memCyc),
    .memStb(memStb),
    .afuAck(afuAck),
    .afuErr(afuErr),
    .fwdActive(uArbiter.reqActive),
    .grantIdx(uArbiter.grantIdx)
);

`default_nettype wire

// ==== verification/vaiMuxTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module vaiMuxTb;

    import vaiPkg::*;

    localparam int NUM_PORTS  = 4;
    localparam int CLK_PERIOD = 8;
    localparam int WINDOW     = 256;
    localparam int STRIDE     = 1024;
    localparam int FAIR_ROUNDS = 3;
    // About 70 bus accesses of at most 25 cycles each, doubled and rounded up.
    localparam int TIMEOUT_CYCLES = 4000;

    logic                                 pClk;
    logic                                 reset;
    logic [NUM_PORTS-1:0]                 afuCyc;
    logic [NUM_PORTS-1:0]                 afuStb;
    logic [NUM_PORTS-1:0]                 afuWe;
    logic [NUM_PORTS-1:0][ADDR_WIDTH-1:0] afuAdr;
    logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] afuDatW;
    logic [NUM_PORTS-1:0][DATA_WIDTH-1:0] afuDatR;
    logic [NUM_PORTS-1:0]                 afuAck;
    logic [NUM_PORTS-1:0]                 afuErr;
    logic                                 memCyc;
    logic                                 memStb;
    logic                                 memWe;
    logic [ADDR_WIDTH-1:0]                memAdr;
    logic [DATA_WIDTH-1:0]                memDatW;
    logic [DATA_WIDTH-1:0]                memDatR;
    logic                                 memAck;
    logic                                 cfgCyc;
    logic                                 cfgStb;
    logic                                 cfgWe;
    logic [ADDR_WIDTH-1:0]                cfgAdr;
    logic [DATA_WIDTH-1:0]                cfgDatW;
    logic [DATA_WIDTH-1:0]                cfgDatR;
    logic                                 cfgAck;

    logic [DATA_WIDTH-1:0] memory [4096];
    logic [ADDR_WIDTH-1:0] lastMemAdr;
    logic                  memSeen;
    logic                  pending;
    int                    delayLeft;
    int                    ackCount;
    int                    cycleCount;
    int                    checkCount;
    int                    errorCount;
    int                    testErrors;
    int                    testCount;
    logic                  runDone;
    logic [15:0]           stimState;
    logic [15:0]           delayState;

    logic [31:0] fairAdr  [NUM_PORTS][FAIR_ROUNDS];
    logic [31:0] fairDat  [NUM_PORTS][FAIR_ROUNDS];
    logic        fairErr  [NUM_PORTS][FAIR_ROUNDS];
    int          fairWait [NUM_PORTS][FAIR_ROUNDS];

    vaiMux #(
        .NUM_SUB_AFUS(NUM_PORTS)
    )
    dut (
        .pClk(pClk), .reset(reset),
        .afuCyc(afuCyc), .afuStb(afuStb), .afuWe(afuWe), .afuAdr(afuAdr),
        .afuDatW(afuDatW), .afuDatR(afuDatR), .afuAck(afuAck), .afuErr(afuErr),
        .memCyc(memCyc), .memStb(memStb), .memWe(memWe), .memAdr(memAdr),
        .memDatW(memDatW), .memDatR(memDatR), .memAck(memAck),
        .cfgCyc(cfgCyc), .cfgStb(cfgStb), .cfgWe(cfgWe), .cfgAdr(cfgAdr),
        .cfgDatW(cfgDatW), .cfgDatR(cfgDatR), .cfgAck(cfgAck)
    );

    initial
    begin
        pClk = 1'b0;
        forever #(CLK_PERIOD / 2) pClk = ~pClk;
    end

    // Galois LFSR, one step per returned bit.
    function automatic logic [31:0] nextRandBits(inout logic [15:0] state, input int n);
        logic [31:0] value;
        value = '0;
        for (int b = 0; b < n; b++)
        begin
            value = {value[30:0], state[0]};
            state = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
        end
        return value;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        checkCount++;
        assert (got === exp)
        else
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        checkCount++;
        assert (cond)
        else
        begin
            $display("Check failed: %s", what);
            errorCount++;
            testErrors++;
        end
    endtask

    task automatic finishTest(input string name);
        $display("Test %s finished with %0d failed checks", name, testErrors);
        testErrors = 0;
        testCount++;
    endtask

    // Inputs change on the falling edge and outputs are read 2 ns later.
    task automatic cfgAccess(input logic we, input int idx, input cfgReg_e sel,
                             input logic [31:0] data, output logic [31:0] rdata);
        int cycles;
        @(negedge pClk);
        cfgCyc  = 1'b1;
        cfgStb  = 1'b1;
        cfgWe   = we;
        cfgAdr  = 32'((idx << CFG_IDX_LSB) | (int'(sel) << 2));
        cfgDatW = data;
        cycles  = 0;
        do
        begin
            @(negedge pClk);
            #2;
            cycles++;
        end
        while (!cfgAck);
        rdata = cfgDatR;
        checkValue("cfgAck cycles", cycles, 1);
        @(negedge pClk);
        cfgCyc = 1'b0;
        cfgStb = 1'b0;
        cfgWe  = 1'b0;
    endtask

    task automatic programPort(input int p, input logic [31:0] offset,
                               input logic [31:0] limit, input logic en);
        logic [31:0] ignored;
        cfgAccess(1'b1, p, cfgOffset, offset, ignored);
        cfgAccess(1'b1, p, cfgLimit, limit, ignored);
        cfgAccess(1'b1, p, cfgEnable, 32'(en), ignored);
    endtask

    task automatic afuAccess(input int p, input logic we, input logic [31:0] adr,
                             input logic [31:0] data, output logic [31:0] rdata,
                             output logic gotErr, output int cycles, output int waited);
        int start;
        @(negedge pClk);
        afuCyc[p]  = 1'b1;
        afuStb[p]  = 1'b1;
        afuWe[p]   = we;
        afuAdr[p]  = adr;
        afuDatW[p] = data;
        #2;
        start  = ackCount;
        cycles = 0;
        do
        begin
            @(negedge pClk);
            #2;
            cycles++;
        end
        while (!(afuAck[p] || afuErr[p]));
        rdata  = afuDatR[p];
        gotErr = afuErr[p];
        waited = ackCount - start - 1;
        @(negedge pClk);
        afuCyc[p] = 1'b0;
        afuStb[p] = 1'b0;
        afuWe[p]  = 1'b0;
    endtask

    // One port of the fair sharing test, which asks again as soon as each write ends.
    task automatic writeBurst(input int p);
        logic [31:0] rdata;
        logic        gotErr;
        int          cycles;
        int          waited;
        for (int r = 0; r < FAIR_ROUNDS; r++)
        begin
            afuAccess(p, 1'b1, fairAdr[p][r], fairDat[p][r], rdata, gotErr, cycles, waited);
            fairErr[p][r]  = gotErr;
            fairWait[p][r] = waited;
        end
    endtask

    // Upstream memory that answers each cycle after 0 to 3 extra cycles.
    always @(negedge pClk)
    begin
        if (reset)
        begin
            memAck  = 1'b0;
            pending = 1'b0;
        end
        else if (memAck)
        begin
            memAck = 1'b0;
        end
        else if (memCyc && memStb)
        begin
            memSeen = 1'b1;
            if (!pending)
            begin
                pending   = 1'b1;
                delayLeft = int'(nextRandBits(delayState, 2));
            end
            if (delayLeft == 0)
            begin
                pending    = 1'b0;
                lastMemAdr = memAdr;
                ackCount++;
                if (memWe)
                begin
                    memory[memAdr[11:0]] = memDatW;
                end
                memDatR = memory[memAdr[11:0]];
                memAck  = 1'b1;
            end
            else
            begin
                delayLeft--;
            end
        end
    end

    always @(posedge pClk)
    begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES)
        begin
            runDone = 1'b1;
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // A run stopped by a failing bound assertion still ends with the fail line.
    final
    begin
        if (!runDone)
        begin
            $display("Result: FAILED");
        end
    end

    initial
    begin
        logic [31:0] rdata;
        logic [31:0] adr;
        logic [31:0] data;
        logic        gotErr;
        int          cycles;
        int          waited;
        afuCyc = '0;
        afuStb = '0;
        afuWe = '0;
        afuAdr = '0;
        afuDatW = '0;
        memDatR = '0;
        memAck = 1'b0;
        cfgCyc = 1'b0;
        cfgStb = 1'b0;
        cfgWe = 1'b0;
        cfgAdr = '0;
        cfgDatW = '0;
        stimState = 16'd99;
        delayState = 16'd99;
        memSeen = 1'b0;
        lastMemAdr = '0;
        runDone = 1'b0;
        for (int k = 0; k < 4096; k++)
        begin
            memory[k] = 32'hC0DE_0000 ^ 32'(k * 32'h0001_0003);
        end
        reset = 1'b1;
        repeat (5) @(posedge pClk);
        @(negedge pClk);
        reset = 1'b0;

        // Nothing is programmed yet, so every window is closed.
        @(negedge pClk);
        #2;
        checkValue("memCyc", memCyc, 0);
        checkValue("memStb", memStb, 0);
        checkValue("afuAck", afuAck, 0);
        checkValue("afuErr", afuErr, 0);
        checkValue("cfgAck", cfgAck, 0);
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            afuAccess(p, 1'b0, 32'(p * 4), 0, rdata, gotErr, cycles, waited);
            checkValue("afuErr", gotErr, 1);
            checkValue("afuErr cycles", cycles, 1);
        end
        checkTrue(!memSeen, "an access after reset reached the upstream bus");
        finishTest("reset state");

        for (int p = 0; p < NUM_PORTS; p++)
        begin
            programPort(p, 32'(p * STRIDE), WINDOW, 1'b1);
        end
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            cfgAccess(1'b0, p, cfgOffset, 0, rdata);
            checkValue("cfgDatR offset", rdata, 32'(p * STRIDE));
            cfgAccess(1'b0, p, cfgLimit, 0, rdata);
            checkValue("cfgDatR limit", rdata, WINDOW);
            cfgAccess(1'b0, p, cfgEnable, 0, rdata);
            checkValue("cfgDatR enable", rdata, 1);
        end
        finishTest("configuration readback");

        for (int p = 0; p < NUM_PORTS; p++)
        begin
            for (int n = 0; n < 2; n++)
            begin
                adr  = nextRandBits(stimState, 8);
                data = nextRandBits(stimState, 32);
                afuAccess(p, 1'b1, adr, data, rdata, gotErr, cycles, waited);
                checkValue("afuErr", gotErr, 0);
                checkTrue(cycles >= 2, "afuAck came less than 2 cycles after afuStb");
                checkValue("memAdr", lastMemAdr, 32'(p * STRIDE) + adr);
                checkValue("memDatW", memory[p * STRIDE + int'(adr)], data);
                afuAccess(p, 1'b0, adr, 0, rdata, gotErr, cycles, waited);
                checkValue("memAdr", lastMemAdr, 32'(p * STRIDE) + adr);
                checkValue("afuDatR", rdata, data);
            end
        end
        finishTest("translation");

        memSeen = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            adr = WINDOW + nextRandBits(stimState, 8);
            afuAccess(p, 1'b1, adr, 32'hDEAD_BEEF, rdata, gotErr, cycles, waited);
            checkValue("afuErr", gotErr, 1);
            checkValue("afuErr cycles", cycles, 1);
        end
        programPort(3, 3 * STRIDE, WINDOW, 1'b0);
        afuAccess(3, 1'b0, 0, 0, rdata, gotErr, cycles, waited);
        checkValue("afuErr", gotErr, 1);
        checkValue("afuErr cycles", cycles, 1);
        checkTrue(!memSeen, "a rejected access reached the upstream bus");
        programPort(3, 3 * STRIDE, WINDOW, 1'b1);
        finishTest("window rejection");

        for (int p = 0; p < NUM_PORTS; p++)
        begin
            for (int r = 0; r < FAIR_ROUNDS; r++)
            begin
                // Each round writes into its own quarter of the window.
                fairAdr[p][r] = 32'(r * 64) + nextRandBits(stimState, 6);
                fairDat[p][r] = nextRandBits(stimState, 32);
            end
        end
        fork
            writeBurst(0);
            writeBurst(1);
            writeBurst(2);
            writeBurst(3);
        join
        for (int p = 0; p < NUM_PORTS; p++)
        begin
            for (int r = 0; r < FAIR_ROUNDS; r++)
            begin
                checkValue("afuErr", fairErr[p][r], 0);
                checkTrue(fairWait[p][r] <= NUM_PORTS - 1,
                          "a port waited for more than 3 other grants");
                checkValue("memDatW", memory[p * STRIDE + int'(fairAdr[p][r])],
                           fairDat[p][r]);
            end
        end
        finishTest("fair sharing");

        runDone = 1'b1;
        $display("Summary: %0d tests, %0d checks, %0d failed", testCount, checkCount, errorCount);
        if (errorCount == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/vaiPkg.sv
source/vaiBusIf.sv
source/vaiOffsetTable.sv
source/vaiAuditTx.sv
source/vaiArbiter.sv
source/vaiMux.sv
verification/vaiMux_checker.sv
verification/vaiMuxTb.sv

// ==== run.sh ====
#!/bin/bash
# Builds the testbench with Verilator, runs it and checks the log.
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module vaiMuxTb \
    -f vlog.f \
    -o vaiMuxSim

./obj_dir/vaiMuxSim 2>&1 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"
